// ==== radio_tx_pkg.sv ====
// Shared constants for the TX control path of the SDR core
// Command word field positions, IQ framing and buffer sizing

package radio_tx_pkg;

  // ----------------------------------------
  // Command word from the Pi SPI transfer
  // ----------------------------------------
  localparam int CMD_W        = 48;

  // Single-bit control fields
  localparam int CMD_CWX_BIT  = 41;
  localparam int CMD_RUN_BIT  = 40;
  localparam int CMD_PTT_BIT  = 32;

  // Register address slice, bits 38:33
  localparam int CMD_ADDR_LSB = 33;
  localparam int CMD_ADDR_W   = 6;

  // Register data in the low bits
  localparam int CMD_DATA_W   = 32;

  // ----------------------------------------
  // IQ sample framing
  // ----------------------------------------
  localparam int BYTE_W       = 8;
  localparam int BYTES_PER_IQ = 4;
  localparam int BYTE_CNT_W   = $clog2(BYTES_PER_IQ);

  // First received byte lands in bits 31:24
  localparam int IQ_W         = BYTE_W * BYTES_PER_IQ;

  // Sample buffer depth, power of two
  localparam int IQ_FIFO_DEPTH = 16;

  // ----------------------------------------
  // CW keying
  // ----------------------------------------
  // Hold time after the last keyed sample, in clock cycles
  localparam int CW_HANG_CYCLES = 32;
  localparam int CW_HANG_W      = $clog2(CW_HANG_CYCLES + 1);

endpackage

// ==== tx_nibble_capture.sv ====
// Captures the Pi's 4-bit DDR TX stream and frames it into IQ samples
// Low nibble on the falling edge, high nibble on the next rising edge

module tx_nibble_capture import radio_tx_pkg::*; (
  input  logic            pi_tx_clk,
  input  logic            rst_n,
  input  logic [3:0]      tx_nibble,
  input  logic            tx_nibble_valid,
  input  logic            run,
  output logic            iq_wr,
  output logic [IQ_W-1:0] iq_wr_data
);

  // Falling-edge half of the current byte
  logic [3:0]               nib_lo;
  // Byte formed from this rising edge and the preceding falling edge
  logic [BYTE_W-1:0]        cur_byte;
  // First three bytes of the sample being framed
  logic [IQ_W-BYTE_W-1:0]   byte_sr;
  // Position of the next byte within the sample
  logic [BYTE_CNT_W-1:0]    byte_cnt;
  logic                     byte_take;
  logic                     last_byte;

  // ----------------------------------------
  // Falling edge, low nibble
  // ----------------------------------------
  always_ff @(negedge pi_tx_clk) begin
    nib_lo <= tx_nibble;
  end

  // Rising-edge nibble is the high half
  assign cur_byte  = {tx_nibble, nib_lo};
  assign byte_take = run & tx_nibble_valid;
  assign last_byte = (byte_cnt == BYTE_CNT_W'(BYTES_PER_IQ - 1));

  // ----------------------------------------
  // Byte counter and write strobe
  // ----------------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_cnt <= '0;
      iq_wr    <= 1'b0;
    end else begin
      // Strobe only on the fourth byte
      iq_wr <= byte_take & last_byte;
      if (!run) begin
        // Alignment restarts when run rises again
        byte_cnt <= '0;
      end else if (tx_nibble_valid) begin
        // Wraps back to byte 0 after the fourth
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Byte shift and sample assembly
  // ----------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (byte_take) begin
      // Oldest byte ends up in the top of the sample
      byte_sr <= {byte_sr[IQ_W-2*BYTE_W-1:0], cur_byte};
      if (last_byte) begin
        iq_wr_data <= {byte_sr, cur_byte};
      end
    end
  end

endmodule

// ==== iq_sample_fifo.sv ====
// Synchronous circular buffer for framed IQ samples
// Registered read port, sticky overflow and underflow flags

module iq_sample_fifo import radio_tx_pkg::*; #(
  parameter int DEPTH = IQ_FIFO_DEPTH
) (
  input  logic                     pi_tx_clk,
  input  logic                     rst_n,
  input  logic                     iq_wr,
  input  logic [IQ_W-1:0]          iq_wr_data,
  input  logic                     iq_rd,
  output logic [IQ_W-1:0]          iq_data,
  output logic                     iq_valid,
  output logic                     fifo_overflow,
  output logic                     fifo_underflow,
  output logic [$clog2(DEPTH):0]   fifo_level
);

  // Pointer width, DEPTH must be a power of two of at least 2
  localparam int AW = $clog2(DEPTH);

  logic [IQ_W-1:0] mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [AW:0]     count;
  logic            full;
  logic            empty;
  logic            do_wr;
  logic            do_rd;

  assign full  = (count == (AW+1)'(DEPTH));
  assign empty = (count == '0);

  // A full buffer drops the write even when a read comes in the same cycle
  assign do_wr = iq_wr & ~full;
  assign do_rd = iq_rd & ~empty;

  assign fifo_level = count;

  // ----------------------------------------
  // Pointers, occupancy and flags
  // ----------------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      iq_valid       <= 1'b0;
      fifo_overflow  <= 1'b0;
      fifo_underflow <= 1'b0;
    end else begin
      // Pointers wrap on the power-of-two boundary
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Read and write together leave the count unchanged
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
      iq_valid <= do_rd;
      // Sticky until reset
      if (iq_wr && full) begin
        fifo_overflow <= 1'b1;
      end
      if (iq_rd && empty) begin
        fifo_underflow <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Storage and registered read data
  // ----------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= iq_wr_data;
    end
    if (do_rd) begin
      iq_data <= mem[rd_ptr];
    end
  end

endmodule

// ==== cmd_decoder.sv ====
// Splits the 48-bit Pi command word into register and control fields
// Fields update one cycle after cmd_valid, together with cmd_rqst

module cmd_decoder import radio_tx_pkg::*; (
  input  logic                  pi_tx_clk,
  input  logic                  rst_n,
  input  logic [CMD_W-1:0]      cmd_word,
  input  logic                  cmd_valid,
  output logic [CMD_ADDR_W-1:0] cmd_addr,
  output logic [CMD_DATA_W-1:0] cmd_data,
  output logic                  cmd_rqst,
  output logic                  run,
  output logic                  ptt,
  output logic                  cwx_enabled
);

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_rqst    <= 1'b0;
      run         <= 1'b0;
      ptt         <= 1'b0;
      cwx_enabled <= 1'b0;
    end else begin
      // One pulse per command for the register slaves
      cmd_rqst <= cmd_valid;
      if (cmd_valid) begin
        run         <= cmd_word[CMD_RUN_BIT];
        ptt         <= cmd_word[CMD_PTT_BIT];
        cwx_enabled <= cmd_word[CMD_CWX_BIT];
      end
    end
  end

  // ----------------------------------------
  // Register address and data
  // ----------------------------------------
  // Held between commands, valid while cmd_rqst is high
  always_ff @(posedge pi_tx_clk) begin
    if (cmd_valid) begin
      cmd_addr <= cmd_word[CMD_ADDR_LSB +: CMD_ADDR_W];
      cmd_data <= cmd_word[CMD_DATA_W-1:0];
    end
  end

endmodule

// ==== tx_keyer.sv ====
// Transmit enable from run, push-to-talk and in-band CW key bits
// CW keying is held by a hang counter between keyed samples

module tx_keyer import radio_tx_pkg::*; (
  input  logic            pi_tx_clk,
  input  logic            rst_n,
  input  logic            run,
  input  logic            ptt,
  input  logic            cwx_enabled,
  input  logic [IQ_W-1:0] iq_data,
  input  logic            iq_valid,
  output logic            tx_on
);

  logic                 lsb_any;
  logic                 cw_key;
  logic [CW_HANG_W-1:0] hang_cnt;
  logic                 cw_active;

  // Key bit is the LSB of any byte in the sample
  always_comb begin
    lsb_any = 1'b0;
    for (int i = 0; i < BYTES_PER_IQ; i++) begin
      lsb_any = lsb_any | iq_data[i*BYTE_W];
    end
  end

  assign cw_key = iq_valid & cwx_enabled & lsb_any;

  // Keyed sample counts at once so tx_on follows iq_valid by one cycle
  assign cw_active = cw_key | (hang_cnt != '0);

  // ----------------------------------------
  // Hang counter
  // ----------------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      hang_cnt <= '0;
    end else if (!run) begin
      hang_cnt <= '0;
    end else if (cw_key) begin
      // Reload on every keyed sample
      hang_cnt <= CW_HANG_W'(CW_HANG_CYCLES);
    end else if (hang_cnt != '0) begin
      hang_cnt <= hang_cnt - 1'b1;
    end
  end

  // ----------------------------------------
  // Registered transmit enable
  // ----------------------------------------
  always_ff @(posedge pi_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_on <= 1'b0;
    end else begin
      tx_on <= run & (ptt | cw_active);
    end
  end

endmodule

// ==== radio_tx_core.sv ====
// Top of the TX control path: nibble capture, sample FIFO,
// command decode and transmit keying, all on pi_tx_clk

module radio_tx_core import radio_tx_pkg::*; (
  input  logic                  pi_tx_clk,
  input  logic                  rst_n,
  // DDR nibble stream from the Pi
  input  logic [3:0]            tx_nibble,
  input  logic                  tx_nibble_valid,
  // Parallel command word after each SPI transfer
  input  logic [CMD_W-1:0]      cmd_word,
  input  logic                  cmd_valid,
  // DAC-side sample reader
  input  logic                  iq_rd,
  output logic [IQ_W-1:0]       iq_data,
  output logic                  iq_valid,
  output logic                  fifo_overflow,
  output logic                  fifo_underflow,
  // Register slave bus
  output logic [CMD_ADDR_W-1:0] cmd_addr,
  output logic [CMD_DATA_W-1:0] cmd_data,
  output logic                  cmd_rqst,
  // Keying
  output logic                  tx_on,
  output logic                  ptt_out
);

  logic            iq_wr;
  logic [IQ_W-1:0] iq_wr_data;
  logic            run;
  logic            ptt;
  logic            cwx_enabled;

  // ----------------------------------------
  // Stream capture and buffering
  // ----------------------------------------
  tx_nibble_capture u_capture (
    .pi_tx_clk       (pi_tx_clk),
    .rst_n           (rst_n),
    .tx_nibble       (tx_nibble),
    .tx_nibble_valid (tx_nibble_valid),
    .run             (run),
    .iq_wr           (iq_wr),
    .iq_wr_data      (iq_wr_data)
  );

  // Level is left for debug and the bound checker
  iq_sample_fifo #(
    .DEPTH (IQ_FIFO_DEPTH)
  ) u_fifo (
    .pi_tx_clk      (pi_tx_clk),
    .rst_n          (rst_n),
    .iq_wr          (iq_wr),
    .iq_wr_data     (iq_wr_data),
    .iq_rd          (iq_rd),
    .iq_data        (iq_data),
    .iq_valid       (iq_valid),
    .fifo_overflow  (fifo_overflow),
    .fifo_underflow (fifo_underflow),
    .fifo_level     ()
  );

  // ----------------------------------------
  // Command decode and keying
  // ----------------------------------------
  cmd_decoder u_cmd (
    .pi_tx_clk   (pi_tx_clk),
    .rst_n       (rst_n),
    .cmd_word    (cmd_word),
    .cmd_valid   (cmd_valid),
    .cmd_addr    (cmd_addr),
    .cmd_data    (cmd_data),
    .cmd_rqst    (cmd_rqst),
    .run         (run),
    .ptt         (ptt),
    .cwx_enabled (cwx_enabled)
  );

  // Keyer watches the samples as they leave the FIFO
  tx_keyer u_keyer (
    .pi_tx_clk   (pi_tx_clk),
    .rst_n       (rst_n),
    .run         (run),
    .ptt         (ptt),
    .cwx_enabled (cwx_enabled),
    .iq_data     (iq_data),
    .iq_valid    (iq_valid),
    .tx_on       (tx_on)
  );

  // External PA switch follows the transmit enable
  assign ptt_out = tx_on;

endmodule

// ==== radio_tx_core_checker.sv ====
// Concurrent checks on the TX core strobes, sticky flags and keying
// Bound into every radio_tx_core instance by the bind at the bottom

module radio_tx_core_checker import radio_tx_pkg::*; (
  input logic                           pi_tx_clk,
  input logic                           rst_n,
  input logic                           iq_rd,
  input logic [$clog2(IQ_FIFO_DEPTH):0] fifo_level,
  input logic                           iq_valid,
  input logic                           cmd_rqst,
  input logic                           fifo_overflow,
  input logic                           fifo_underflow,
  input logic                           run,
  input logic                           tx_on
);

  // Failure counts per property, summed by the testbench
  int empty_read_fails = 0;
  int rqst_width_fails = 0;
  int sticky_fails     = 0;
  int key_fails        = 0;

  // No sample comes back from a read of an empty buffer
  a_empty_read : assert property (@(posedge pi_tx_clk) disable iff (!rst_n)
    (iq_rd && (fifo_level == '0)) |=> !iq_valid)
  else begin
    $error("iq_valid after a read of an empty FIFO");
    empty_read_fails++;
  end

  // Command strobe is a single cycle
  a_rqst_width : assert property (@(posedge pi_tx_clk) disable iff (!rst_n)
    cmd_rqst |=> !cmd_rqst)
  else begin
    $error("cmd_rqst high for more than one cycle");
    rqst_width_fails++;
  end

  // Error flags hold until reset
  a_sticky : assert property (@(posedge pi_tx_clk) disable iff (!rst_n)
    !$fell(fifo_overflow) && !$fell(fifo_underflow))
  else begin
    $error("sticky FIFO flag fell while out of reset");
    sticky_fails++;
  end

  // tx_on is registered, so it follows run low one cycle later
  a_key_run : assert property (@(posedge pi_tx_clk) disable iff (!rst_n)
    !run |=> !tx_on)
  else begin
    $error("tx_on high while run is low");
    key_fails++;
  end

endmodule

bind radio_tx_core radio_tx_core_checker u_checker (
  .pi_tx_clk      (pi_tx_clk),
  .rst_n          (rst_n),
  .iq_rd          (iq_rd),
  .fifo_level     (u_fifo.fifo_level),
  .iq_valid       (iq_valid),
  .cmd_rqst       (cmd_rqst),
  .fifo_overflow  (fifo_overflow),
  .fifo_underflow (fifo_underflow),
  .run            (run),
  .tx_on          (tx_on)
);

// ==== tb_radio_tx_core.sv ====
// Testbench for the TX control path core
// Runs the operations in radio_tx_testdata.txt against a FIFO and keying model

module tb_radio_tx_core import radio_tx_pkg::*; ();

  localparam int CLK_PERIOD = 8;

  logic                  pi_tx_clk = 1'b0;
  logic                  rst_n;
  logic [3:0]            tx_nibble;
  logic                  tx_nibble_valid;
  logic [CMD_W-1:0]      cmd_word;
  logic                  cmd_valid;
  logic                  iq_rd;
  logic [IQ_W-1:0]       iq_data;
  logic                  iq_valid;
  logic                  fifo_overflow;
  logic                  fifo_underflow;
  logic [CMD_ADDR_W-1:0] cmd_addr;
  logic [CMD_DATA_W-1:0] cmd_data;
  logic                  cmd_rqst;
  logic                  tx_on;
  logic                  ptt_out;

  // Parsed operations
  string       ops[$];
  logic [63:0] arg_a[$];
  int          arg_b[$];
  int          budget = 0;
  logic        loaded = 1'b0;
  int          errors = 0;
  int          checks = 0;

  // Reference model state
  logic [IQ_W-1:0] m_q[$];
  logic [IQ_W-1:0] m_acc = '0;
  int              m_cnt = 0;
  logic            m_run = 1'b0;
  logic            m_ptt = 1'b0;
  logic            m_cwx = 1'b0;
  logic            m_ovf = 1'b0;
  logic            m_udf = 1'b0;
  logic [31:0]     rnd = 32'd44;

  radio_tx_core u_radio_tx_core (.*);

  always #(CLK_PERIOD / 2) pi_tx_clk = ~pi_tx_clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare(input string name, input logic [63:0] want, input logic [63:0] got);
    checks++;
    if (want !== got) begin
      $display("CHECK FAILED t=%0t %s expected %0h actual %0h", $time, name, want, got);
      errors++;
    end
  endtask

  // Next falling edge, strobes back to idle
  task automatic step();
    @(negedge pi_tx_clk);
    tx_nibble_valid <= 1'b0;
    cmd_valid       <= 1'b0;
    iq_rd           <= 1'b0;
  endtask

  // Low nibble goes out a cycle early so the falling edge sees it settled
  task automatic send_byte(input logic [7:0] b);
    step();
    tx_nibble <= b[3:0];
    step();
    tx_nibble       <= b[7:4];
    tx_nibble_valid <= 1'b1;
    if (m_run) begin
      m_acc = {m_acc[IQ_W-BYTE_W-1:0], b};
      m_cnt++;
      if (m_cnt == BYTES_PER_IQ) begin
        m_cnt = 0;
        if (m_q.size() < IQ_FIFO_DEPTH) begin
          m_q.push_back(m_acc);
        end else begin
          m_ovf = 1'b1;
        end
      end
    end
  endtask

  task automatic issue_cmd(input logic [CMD_W-1:0] w);
    step();
    cmd_word  <= w;
    cmd_valid <= 1'b1;
    // CWX bit 41, run bit 40, PTT bit 32
    m_run = w[40];
    m_ptt = w[32];
    m_cwx = w[41];
    // Framing restarts once run is low
    if (!m_run) begin
      m_cnt = 0;
    end
    step();
    compare("cmd_rqst", 64'(1'b1), 64'(cmd_rqst));
    // Address in bits 38:33, data in the low 32 bits
    compare("cmd_addr", 64'(w[38:33]), 64'(cmd_addr));
    compare("cmd_data", 64'(w[31:0]), 64'(cmd_data));
    step();
    compare("cmd_rqst", 64'(1'b0), 64'(cmd_rqst));
    compare("tx_on", 64'(m_run & m_ptt), 64'(tx_on));
    compare("ptt_out", 64'(m_run & m_ptt), 64'(ptt_out));
  endtask

  task automatic read_sample();
    logic [IQ_W-1:0] want;
    logic            keyed;
    step();
    iq_rd <= 1'b1;
    step();
    keyed = 1'b0;
    if (m_q.size() == 0) begin
      m_udf = 1'b1;
      compare("iq_valid", 64'(1'b0), 64'(iq_valid));
      compare("fifo_underflow", 64'(1'b1), 64'(fifo_underflow));
    end else begin
      want = m_q.pop_front();
      compare("iq_valid", 64'(1'b1), 64'(iq_valid));
      compare("iq_data", 64'(want), 64'(iq_data));
      keyed = m_run & m_cwx & (want[24] | want[16] | want[8] | want[0]);
    end
    // Keyed cycle plus the full hang countdown
    if (keyed) begin
      for (int j = 0; j <= CW_HANG_CYCLES; j++) begin
        step();
        compare("tx_on", 64'(1'b1), 64'(tx_on));
      end
    end
    step();
    compare("tx_on", 64'(m_run & m_ptt), 64'(tx_on));
  endtask

  task automatic check_flags(input logic ovf, input logic udf);
    step();
    if (ovf !== m_ovf || udf !== m_udf) begin
      $display("Test data flags disagree with the FIFO model at t=%0t", $time);
      errors++;
    end
    compare("fifo_overflow", 64'(ovf), 64'(fifo_overflow));
    compare("fifo_underflow", 64'(udf), 64'(fifo_underflow));
  endtask

  // ----------------------------------------
  // Data file and cycle budget
  // ----------------------------------------
  task automatic load_testdata();
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [63:0] a;
    int          b;
    fd = $fopen("radio_tx_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open radio_tx_testdata.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      a = '0;
      b = 0;
      n = $fgets(line, fd);
      if (n <= 1 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s", op);
      if (op == "cmd" || op == "word") begin
        n = $sscanf(line, "%s %h", op, a);
      end else begin
        n = $sscanf(line, "%s %d %d", op, a, b);
      end
      case (op)
        "cmd":    budget += 3;
        "bytes":  budget += 2 * int'(a) + 1;
        "word":   budget += 2 * BYTES_PER_IQ + 1;
        "read":   budget += int'(a) * (CW_HANG_CYCLES + 4);
        "idle":   budget += int'(a);
        "expect": budget += 1;
        default: begin
          $display("Unknown operation %s in the test data", op);
          errors++;
          continue;
        end
      endcase
      ops.push_back(op);
      arg_a.push_back(a);
      arg_b.push_back(b);
    end
    $fclose(fd);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int errs_before;
    int assert_fails;
    rst_n           = 1'b0;
    tx_nibble       = '0;
    tx_nibble_valid = 1'b0;
    cmd_word        = '0;
    cmd_valid       = 1'b0;
    iq_rd           = 1'b0;
    load_testdata();
    loaded = 1'b1;
    repeat (16) @(posedge pi_tx_clk);
    step();
    rst_n <= 1'b1;
    foreach (ops[i]) begin
      errs_before = errors;
      case (ops[i])
        "cmd": issue_cmd(arg_a[i][CMD_W-1:0]);
        "bytes": begin
          repeat (int'(arg_a[i])) begin
            rnd = xorshift(rnd);
            send_byte(rnd[7:0]);
          end
          step();
        end
        "word": begin
          for (int k = BYTES_PER_IQ - 1; k >= 0; k--) begin
            send_byte(arg_a[i][k*BYTE_W +: BYTE_W]);
          end
          step();
        end
        "read":   repeat (int'(arg_a[i])) read_sample();
        "idle":   repeat (int'(arg_a[i])) step();
        "expect": check_flags(arg_a[i][0], arg_b[i][0]);
        default:  ;
      endcase
      $display("test %0d %s %0h: %s", i + 1, ops[i], arg_a[i],
               (errors == errs_before) ? "ok" : "failed");
    end
    // Bound assertions count their own failures
    assert_fails = u_radio_tx_core.u_checker.empty_read_fails
                 + u_radio_tx_core.u_checker.rqst_width_fails
                 + u_radio_tx_core.u_checker.sticky_fails
                 + u_radio_tx_core.u_checker.key_fails;
    if (assert_fails != 0) begin
      $display("%0d assertion failures in the bound checker", assert_fails);
      errors += assert_fails;
    end
    $display("tests %0d, checks %0d, errors %0d", ops.size(), checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Budget from the data file plus reset and margin
  initial begin
    wait (loaded);
    #((budget + 216) * CLK_PERIOD);
    $display("Watchdog timeout after %0d cycles, the run did not finish", budget + 216);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== radio_tx_testdata.txt ====
# TX core operations in order: cmd <word hex> | bytes <count> | word <sample hex>
# read <count> | idle <cycles> | expect <overflow> <underflow>
cmd 010a12345678
bytes 8
read 2
cmd 0006deadbeef
bytes 8
read 1
expect 0 1
cmd 0100000000ff
bytes 68
expect 1 1
read 17
expect 1 1
cmd 010100000001
cmd 010000000002
cmd 030000000003
word 00000001
read 1
cmd 010000000004
word 00000001
read 1
cmd 000000000000
idle 4

// ==== radio_tx_core.f ====
radio_tx_pkg.sv
tx_nibble_capture.sv
iq_sample_fifo.sv
cmd_decoder.sv
tx_keyer.sv
radio_tx_core.sv
radio_tx_core_checker.sv
tb_radio_tx_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the TX core testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_radio_tx_core \
  -f radio_tx_core.f -o sim_radio_tx_core
./obj_dir/sim_radio_tx_core +verilator+error+limit+1000 | tee sim.log
if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
grep -q "SIMULATION PASSED" sim.log
